/* design/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

   // Architectural sizes
   localparam int NUM_GPR = 8;
   localparam int DATA_W  = 32;
   localparam int IMM_W   = 8;

   // Bit positions inside flags_t
   localparam int FLAG_CF = 0;
   localparam int FLAG_ZF = 1;
   localparam int FLAG_SF = 2;
   localparam int FLAG_OF = 3;

   typedef logic [$clog2(NUM_GPR)-1:0] gpr_id_t;
   typedef logic [DATA_W-1:0]          data_t;
   typedef logic [IMM_W-1:0]           imm8_t;

   // EFLAGS subset, cf in bit 0 up to of in bit 3
   typedef logic [3:0] flags_t;

   // Group-1 ALU kinds in opcode order
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_OR  = 3'd1,
      ALU_ADC = 3'd2,
      ALU_SBB = 3'd3,
      ALU_AND = 3'd4,
      ALU_SUB = 3'd5,
      ALU_XOR = 3'd6,
      ALU_CMP = 3'd7
   } aluk_e;

   // Incoming instruction word
   typedef struct packed {
      logic    imm_pres;
      aluk_e   aluk;
      gpr_id_t dr;
      gpr_id_t sr;
      imm8_t   imm;
   } instr_t;

   // Decode to operand latch
   typedef struct packed {
      logic    valid;
      aluk_e   aluk;
      gpr_id_t dr;
      gpr_id_t sr;
      logic    imm_pres;
      data_t   imm_sext;
      logic    ld_gpr;
   } dec_t;

   // Operand to execute latch
   typedef struct packed {
      logic    valid;
      aluk_e   aluk;
      gpr_id_t dr;
      logic    ld_gpr;
      data_t   a;
      data_t   b;
   } opnd_t;

   // Retirement record
   typedef struct packed {
      gpr_id_t dr;
      logic    ld_gpr;
      data_t   data;
      flags_t  flags;
   } wb_t;

endpackage

`default_nettype wire

/* design/decode_stage.sv */
`default_nettype none

module decode_stage (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire logic             instr_valid,
   input  wire pipe_pkg::instr_t instr,
   output pipe_pkg::dec_t        dec
);
   import pipe_pkg::*;

   logic   in_valid;
   instr_t in_instr;
   dec_t   dec_d;

   // Input capture ahead of the decode register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_valid <= 1'b0;
      end else begin
         in_valid <= instr_valid;
      end
   end

   always_ff @(posedge clk) begin
      in_instr <= instr;
   end

   always_comb begin
      dec_d.valid    = in_valid;
      dec_d.aluk     = in_instr.aluk;
      dec_d.dr       = in_instr.dr;
      dec_d.sr       = in_instr.sr;
      dec_d.imm_pres = in_instr.imm_pres;
      // Sign extension as in opcode 83
      dec_d.imm_sext = {{(DATA_W-IMM_W){in_instr.imm[IMM_W-1]}}, in_instr.imm};
      // cmp only updates flags
      dec_d.ld_gpr   = (in_instr.aluk != ALU_CMP);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dec <= '0;
      end else begin
         dec <= dec_d;
      end
   end

   a_instr_known: assert property (@(posedge clk) disable iff (!rst_n)
      instr_valid |-> !$isunknown(instr));

endmodule

`default_nettype wire

/* design/register_file.sv */
`default_nettype none

module register_file (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire pipe_pkg::gpr_id_t rd_addr_a,
   input  wire pipe_pkg::gpr_id_t rd_addr_b,
   output pipe_pkg::data_t        rd_data_a,
   output pipe_pkg::data_t        rd_data_b,
   input  wire logic              wr_en,
   input  wire pipe_pkg::gpr_id_t wr_addr,
   input  wire pipe_pkg::data_t   wr_data
);
   import pipe_pkg::*;

   // EAX through EDI, indexed by the x86 register number
   data_t gpr [NUM_GPR];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_GPR; i++) begin
            gpr[i] <= '0;
         end
      end else if (wr_en) begin
         gpr[wr_addr] <= wr_data;
      end
   end

   // Reads are asynchronous, a same-cycle write is covered by forwarding
   assign rd_data_a = gpr[rd_addr_a];
   assign rd_data_b = gpr[rd_addr_b];

endmodule

`default_nettype wire

/* design/operand_fetch.sv */
`default_nettype none

module operand_fetch (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire pipe_pkg::dec_t    dec,
   input  wire logic              ex_valid,
   input  wire pipe_pkg::wb_t     ex_res,
   input  wire logic              wb_valid,
   input  wire pipe_pkg::wb_t     wb_res,
   output pipe_pkg::gpr_id_t      rd_addr_a,
   output pipe_pkg::gpr_id_t      rd_addr_b,
   input  wire pipe_pkg::data_t   rd_data_a,
   input  wire pipe_pkg::data_t   rd_data_b,
   output pipe_pkg::opnd_t        opnd
);
   import pipe_pkg::*;

   logic  ex_fwd_ok;
   logic  wb_fwd_ok;
   data_t src_a;
   data_t src_b;
   opnd_t opnd_d;

   // Newest in-flight writer wins, the register file is the fallback
   function automatic data_t pick_source(
      input gpr_id_t id,
      input data_t   rf_data
   );
      data_t val;
      if (ex_fwd_ok && ex_res.dr == id) begin
         val = ex_res.data;
      end else if (wb_fwd_ok && wb_res.dr == id) begin
         val = wb_res.data;
      end else begin
         val = rf_data;
      end
      return val;
   endfunction

   // dr is both destination and first source
   assign rd_addr_a = dec.dr;
   assign rd_addr_b = dec.sr;

   assign ex_fwd_ok = ex_valid && ex_res.ld_gpr;
   assign wb_fwd_ok = wb_valid && wb_res.ld_gpr;

   always_comb begin
      src_a = pick_source(dec.dr, rd_data_a);
      src_b = pick_source(dec.sr, rd_data_b);
   end

   always_comb begin
      opnd_d.valid  = dec.valid;
      opnd_d.aluk   = dec.aluk;
      opnd_d.dr     = dec.dr;
      opnd_d.ld_gpr = dec.ld_gpr;
      opnd_d.a      = src_a;
      // Immediate form replaces the second register
      opnd_d.b      = dec.imm_pres ? dec.imm_sext : src_b;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         opnd <= '0;
      end else begin
         opnd <= opnd_d;
      end
   end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`default_nettype none

module execute_stage (
   input  wire logic           clk,
   input  wire logic           rst_n,
   input  wire pipe_pkg::opnd_t opnd,
   output logic                ex_valid,
   output pipe_pkg::wb_t       ex_res
);
   import pipe_pkg::*;

   flags_t          flags_q;
   flags_t          flags_d;
   logic            is_sub;
   logic            carry_in;
   data_t           b_op;
   logic [DATA_W:0] sum;
   data_t           result;

   // Shared adder for the arithmetic kinds
   always_comb begin
      is_sub   = opnd.aluk inside {ALU_SUB, ALU_SBB, ALU_CMP};
      carry_in = (opnd.aluk inside {ALU_ADC, ALU_SBB}) ? flags_q[FLAG_CF] : 1'b0;
      b_op     = is_sub ? ~opnd.b : opnd.b;
      // Subtract is a + ~b + 1, sbb drops the +1 when CF is set
      sum      = {1'b0, opnd.a} + {1'b0, b_op} + {{DATA_W{1'b0}}, is_sub ^ carry_in};
   end

   always_comb begin
      flags_d = '0;
      case (opnd.aluk)
         ALU_OR: begin
            result = opnd.a | opnd.b;
         end
         ALU_AND: begin
            result = opnd.a & opnd.b;
         end
         ALU_XOR: begin
            result = opnd.a ^ opnd.b;
         end
         default: begin
            result           = sum[DATA_W-1:0];
            // Borrow is the inverted carry out
            flags_d[FLAG_CF] = sum[DATA_W] ^ is_sub;
            flags_d[FLAG_OF] = (opnd.a[DATA_W-1] == b_op[DATA_W-1]) &&
                               (result[DATA_W-1] != opnd.a[DATA_W-1]);
         end
      endcase
      flags_d[FLAG_ZF] = (result == '0);
      flags_d[FLAG_SF] = result[DATA_W-1];
   end

   // Architectural flags, read back by the next adc or sbb
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         flags_q <= '0;
      end else if (opnd.valid) begin
         flags_q <= flags_d;
      end
   end

   assign ex_valid = opnd.valid;

   always_comb begin
      ex_res.dr     = opnd.dr;
      ex_res.ld_gpr = opnd.ld_gpr;
      ex_res.data   = result;
      ex_res.flags  = flags_d;
   end

   a_cmp_no_write: assert property (@(posedge clk) disable iff (!rst_n)
      (opnd.valid && opnd.aluk == ALU_CMP) |-> !opnd.ld_gpr);

endmodule

`default_nettype wire

/* design/writeback_stage.sv */
`default_nettype none

module writeback_stage (
   input  wire logic          clk,
   input  wire logic          rst_n,
   input  wire logic          ex_valid,
   input  wire pipe_pkg::wb_t ex_res,
   output logic               wb_valid,
   output pipe_pkg::wb_t      wb,
   output logic               wr_en,
   output pipe_pkg::gpr_id_t  wr_addr,
   output pipe_pkg::data_t    wr_data
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= ex_valid;
      end
   end

   // Retiring record
   always_ff @(posedge clk) begin
      wb <= ex_res;
   end

   // Register file write port, cmp retires without a write
   assign wr_en   = wb_valid && wb.ld_gpr;
   assign wr_addr = wb.dr;
   assign wr_data = wb.data;

   a_write_known: assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> !$isunknown({wr_addr, wr_data}));

endmodule

`default_nettype wire

/* design/pipeline.sv */
`default_nettype none

module pipeline (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire logic             instr_valid,
   input  wire pipe_pkg::instr_t instr,
   output logic                  wb_valid,
   output pipe_pkg::wb_t         wb
);
   import pipe_pkg::*;

   dec_t    dec;
   opnd_t   opnd;
   logic    ex_valid;
   wb_t     ex_res;
   gpr_id_t rd_addr_a;
   gpr_id_t rd_addr_b;
   data_t   rd_data_a;
   data_t   rd_data_b;
   logic    wr_en;
   gpr_id_t wr_addr;
   data_t   wr_data;

   decode_stage u_decode_stage (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .dec         (dec)
   );

   register_file u_register_file (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data)
   );

   // Forwarding taps come from execute and writeback
   operand_fetch u_operand_fetch (
      .clk       (clk),
      .rst_n     (rst_n),
      .dec       (dec),
      .ex_valid  (ex_valid),
      .ex_res    (ex_res),
      .wb_valid  (wb_valid),
      .wb_res    (wb),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .opnd      (opnd)
   );

   execute_stage u_execute_stage (
      .clk      (clk),
      .rst_n    (rst_n),
      .opnd     (opnd),
      .ex_valid (ex_valid),
      .ex_res   (ex_res)
   );

   writeback_stage u_writeback_stage (
      .clk      (clk),
      .rst_n    (rst_n),
      .ex_valid (ex_valid),
      .ex_res   (ex_res),
      .wb_valid (wb_valid),
      .wb       (wb),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

endmodule

`default_nettype wire

/* dv/alu_model.svh */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Architectural state of a machine that runs one instruction at a time
data_t  model_gpr [NUM_GPR];
flags_t model_flags;

function automatic void model_reset();
   for (int i = 0; i < NUM_GPR; i++) begin
      model_gpr[i] = '0;
   end
   model_flags = '0;
endfunction

// Runs one instruction to completion and returns what should retire
function automatic wb_t model_step(input instr_t in);
   data_t       a;
   data_t       b;
   data_t       r;
   logic [63:0] wide;
   longint      exact;
   longint      cin;
   logic        is_arith;
   wb_t         res;
   a = model_gpr[in.dr];
   // Opcode 83 style immediate
   b = in.imm_pres ? {{(DATA_W-IMM_W){in.imm[IMM_W-1]}}, in.imm} : model_gpr[in.sr];
   cin = 0;
   if (in.aluk inside {ALU_ADC, ALU_SBB}) begin
      cin = model_flags[FLAG_CF];
   end
   is_arith = 1'b1;
   res.flags = '0;
   exact = 0;
   case (in.aluk)
      ALU_ADD, ALU_ADC: begin
         wide = 64'(a) + 64'(b) + 64'(cin);
         r = wide[DATA_W-1:0];
         res.flags[FLAG_CF] = wide[DATA_W];
         exact = longint'($signed(a)) + longint'($signed(b)) + cin;
      end
      ALU_SUB, ALU_SBB, ALU_CMP: begin
         r = a - b - data_t'(cin);
         // Borrow when the subtrahend is larger than the minuend
         res.flags[FLAG_CF] = (64'(a) < (64'(b) + 64'(cin)));
         exact = longint'($signed(a)) - longint'($signed(b)) - cin;
      end
      ALU_OR: begin
         r = a | b;
         is_arith = 1'b0;
      end
      ALU_AND: begin
         r = a & b;
         is_arith = 1'b0;
      end
      default: begin
         r = a ^ b;
         is_arith = 1'b0;
      end
   endcase
   // Signed overflow when the exact result does not fit in 32 bits
   if (is_arith) begin
      res.flags[FLAG_OF] = (exact != longint'($signed(r)));
   end
   res.flags[FLAG_ZF] = (r == '0);
   res.flags[FLAG_SF] = r[DATA_W-1];
   res.dr     = in.dr;
   res.ld_gpr = (in.aluk != ALU_CMP);
   res.data   = r;
   if (res.ld_gpr) begin
      model_gpr[in.dr] = r;
   end
   model_flags = res.flags;
   return res;
endfunction

`endif

/* dv/tb_pipeline.sv */
`default_nettype none

module tb_pipeline;
   import pipe_pkg::*;

   localparam int          NUM_INSTR  = 2000;
   localparam int          LATENCY    = 4;
   // Directed bursts plus 70% density stay below two cycles per instruction
   localparam int          MAX_CYCLES = 2 * NUM_INSTR;
   localparam int unsigned SEED       = 32'h28d9_1835;

   typedef struct packed {
      wb_t         res;
      logic [31:0] issue_cycle;
   } pending_t;

   logic   clk;
   logic   rst_n;
   logic   instr_valid;
   instr_t instr;
   logic   wb_valid;
   wb_t    wb;

   pending_t    exp_q [$];
   logic [31:0] cycle;
   int          issued;

   `include "alu_model.svh"

   pipeline u_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .wb_valid    (wb_valid),
      .wb          (wb)
   );

   always #4 clk = ~clk;

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES) begin
         fail_now($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
      end
   end

   function automatic instr_t make_instr(
      input aluk_e   aluk,
      input gpr_id_t dr,
      input gpr_id_t sr,
      input logic    imm_pres,
      input imm8_t   imm
   );
      instr_t in;
      in.aluk     = aluk;
      in.dr       = dr;
      in.sr       = sr;
      in.imm_pres = imm_pres;
      in.imm      = imm;
      return in;
   endfunction

   function automatic instr_t random_instr();
      return make_instr(aluk_e'($urandom_range(7)), gpr_id_t'($urandom),
                        gpr_id_t'($urandom), ($urandom_range(1) == 1), imm8_t'($urandom));
   endfunction

   // One strobe, applied to the model in program order
   task automatic issue(input instr_t in);
      pending_t p;
      @(posedge clk);
      #1;
      instr_valid = 1'b1;
      instr       = in;
      p.res         = model_step(in);
      p.issue_cycle = cycle;
      exp_q.push_back(p);
      issued++;
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
      // Junk on the bus while no strobe is present
      instr = random_instr();
   endtask

   task automatic check_retire();
      pending_t p;
      assert (exp_q.size() != 0) else begin
         fail_now("wb_valid was raised with no instruction outstanding");
      end
      p = exp_q.pop_front();
      assert (cycle == p.issue_cycle + LATENCY) else begin
         fail_now($sformatf("error: wb_valid cycle expected %h got %h",
                            p.issue_cycle + LATENCY, cycle));
      end
      assert (wb.dr == p.res.dr) else begin
         fail_now($sformatf("error: wb.dr expected %h got %h", p.res.dr, wb.dr));
      end
      assert (wb.ld_gpr == p.res.ld_gpr) else begin
         fail_now($sformatf("error: wb.ld_gpr expected %h got %h", p.res.ld_gpr, wb.ld_gpr));
      end
      assert (wb.data == p.res.data) else begin
         fail_now($sformatf("error: wb.data expected %h got %h", p.res.data, wb.data));
      end
      assert (wb.flags == p.res.flags) else begin
         fail_now($sformatf("error: wb.flags expected %h got %h", p.res.flags, wb.flags));
      end
   endtask

   // Outputs are settled at the falling edge
   always @(negedge clk) begin
      if (rst_n && wb_valid) begin
         check_retire();
      end
   end

   initial begin
      gpr_id_t r;
      gpr_id_t other;
      aluk_e   k;
      clk         = 1'b0;
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      cycle       = '0;
      issued      = 0;
      void'($urandom(SEED));
      model_reset();
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // Quiet period, any wb_valid here has nothing outstanding
      repeat (6) idle_cycle();

      // Producer and consumer at distance 1 to 4
      for (int d = 1; d <= 4; d++) begin
         repeat (8) begin
            r = gpr_id_t'($urandom);
            issue(make_instr(ALU_ADD, r, r, 1'b1, imm8_t'($urandom)));
            for (int f = 1; f < d; f++) begin
               other = r + gpr_id_t'(f);
               issue(make_instr(ALU_XOR, other, gpr_id_t'($urandom), 1'b0, '0));
            end
            k = aluk_e'($urandom_range(7));
            if ($urandom_range(1) == 1) begin
               issue(make_instr(k, r, gpr_id_t'($urandom), 1'b0, '0));
            end else begin
               other = r + gpr_id_t'(4);
               issue(make_instr(k, other, r, 1'b0, '0));
            end
         end
      end

      // Carry chains, 0xff extends to all ones and forces frequent carries
      repeat (40) begin
         case ($urandom_range(2))
            0: k = ALU_ADD;
            1: k = ALU_SUB;
            default: k = ALU_CMP;
         endcase
         issue(make_instr(k, gpr_id_t'($urandom), gpr_id_t'($urandom), 1'b1,
                          ($urandom_range(1) == 1) ? 8'hff : imm8_t'($urandom)));
         repeat (3) begin
            k = ($urandom_range(1) == 1) ? ALU_ADC : ALU_SBB;
            issue(make_instr(k, gpr_id_t'($urandom), gpr_id_t'($urandom),
                             ($urandom_range(1) == 1), imm8_t'($urandom)));
         end
         idle_cycle();
      end

      // cmp must leave its dr untouched for the next reader
      repeat (20) begin
         r = gpr_id_t'($urandom);
         issue(make_instr(ALU_CMP, r, gpr_id_t'($urandom), ($urandom_range(1) == 1),
                          imm8_t'($urandom)));
         issue(make_instr(ALU_OR, r, r, 1'b1, 8'h00));
      end

      // Random traffic with random gaps
      while (issued < NUM_INSTR) begin
         if ($urandom_range(99) < 70) begin
            issue(random_instr());
         end else begin
            idle_cycle();
         end
      end
      idle_cycle();

      // Drain the pipeline, then watch for a stray wb_valid
      repeat (LATENCY + 8) @(posedge clk);
      if (exp_q.size() == 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         fail_now("results still outstanding at the end of the run");
      end
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+dv
design/pipe_pkg.sv
design/decode_stage.sv
design/register_file.sv
design/operand_fetch.sv
design/execute_stage.sv
design/writeback_stage.sv
design/pipeline.sv
dv/tb_pipeline.sv

/* Bender.yml */
package:
  name: x86_alu_pipeline

sources:
  - design/pipe_pkg.sv
  - design/decode_stage.sv
  - design/register_file.sv
  - design/operand_fetch.sv
  - design/execute_stage.sv
  - design/writeback_stage.sv
  - design/pipeline.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_pipeline.sv
